/* common/pcie_qm_config.svh */
`ifndef PCIE_QM_CONFIG_SVH
`define PCIE_QM_CONFIG_SVH

// queue count sets the depth of every context table
`define QM_NB_QUEUES        16
`define QM_QUEUE_IDX_WIDTH  4

// host MMIO bus
`define QM_PAGE_LSB         12
`define QM_PCIE_ADDR_WIDTH  16
`define QM_PCIE_DATA_WIDTH  512
`define QM_PCIE_BE_WIDTH    64

// one 32-bit slot per table word
`define QM_WORD_WIDTH       32
`define QM_REG_BYTES        4

// slot offsets inside a ring's register group
`define QM_SLOT_TAIL        0
`define QM_SLOT_HEAD        1
`define QM_SLOT_LADDR       2
`define QM_SLOT_HADDR       3

// packet ring starts after the descriptor ring
`define QM_RING_SLOTS       4

// registered table read
`define QM_RAM_LATENCY      2

`endif

/* common/pcie_qm_pkg.sv */
`include "pcie_qm_config.svh"

package pcie_qm_pkg;

// host-port operation in a given cycle
typedef enum int {
    MMIO_IDLE,
    MMIO_WRITE,
    MMIO_READ
} mmio_op_t;

// host read waiting for a free table port
typedef enum int {
    RD_IDLE,
    RD_PENDING
} rd_state_t;

// what a bank's lookup port does this cycle
typedef enum int {
    PORTA_IDLE,
    PORTA_LOOKUP,
    PORTA_TAIL_WR
} porta_op_t;

// one ring's context for one queue
typedef struct packed {
    logic [`QM_WORD_WIDTH-1:0]   head;
    logic [`QM_WORD_WIDTH-1:0]   tail;
    // high word in the upper half
    logic [2*`QM_WORD_WIDTH-1:0] buf_addr;
} queue_ctx_t;

endpackage

/* common/qtable_if.sv */
`timescale 1ns/100ps
`include "pcie_qm_config.svh"

interface qtable_if;

// host-side table access, one ring
logic [`QM_QUEUE_IDX_WIDTH-1:0] addr;
logic                           rd_en;
logic                           head_wr_en;
logic                           laddr_wr_en;
logic                           haddr_wr_en;
logic [`QM_WORD_WIDTH-1:0]      head_wr_data;
logic [`QM_WORD_WIDTH-1:0]      laddr_wr_data;
logic [`QM_WORD_WIDTH-1:0]      haddr_wr_data;

// read return from the bank
logic [`QM_WORD_WIDTH-1:0]      rd_tail;
logic [`QM_WORD_WIDTH-1:0]      rd_head;
logic [`QM_WORD_WIDTH-1:0]      rd_laddr;
logic [`QM_WORD_WIDTH-1:0]      rd_haddr;
logic                           rd_valid;

modport ctrl (
    output addr, rd_en, head_wr_en, laddr_wr_en, haddr_wr_en,
    output head_wr_data, laddr_wr_data, haddr_wr_data
);

modport bank (
    input  addr, rd_en, head_wr_en, laddr_wr_en, haddr_wr_en,
    input  head_wr_data, laddr_wr_data, haddr_wr_data,
    output rd_tail, rd_head, rd_laddr, rd_haddr, rd_valid
);

modport sink (
    input rd_tail, rd_head, rd_laddr, rd_haddr, rd_valid
);

endinterface

/* queue_table/qtable_ram.sv */
`timescale 1ns/100ps
`include "pcie_qm_config.svh"

module qtable_ram (
    input  logic                            pcie_clk,
    input  logic [`QM_QUEUE_IDX_WIDTH-1:0]  addr_a,
    input  logic [`QM_QUEUE_IDX_WIDTH-1:0]  addr_b,
    input  logic [`QM_WORD_WIDTH-1:0]       wr_data_a,
    input  logic [`QM_WORD_WIDTH-1:0]       wr_data_b,
    input  logic                            rd_en_a,
    input  logic                            rd_en_b,
    input  logic                            wr_en_a,
    input  logic                            wr_en_b,
    output logic [`QM_WORD_WIDTH-1:0]       rd_data_a,
    output logic [`QM_WORD_WIDTH-1:0]       rd_data_b
);

logic [`QM_WORD_WIDTH-1:0] mem [`QM_NB_QUEUES];
logic [`QM_WORD_WIDTH-1:0] q_a;
logic [`QM_WORD_WIDTH-1:0] q_b;

always_ff @(posedge pcie_clk) begin
    if (wr_en_a) begin
        mem[addr_a] <= wr_data_a;
    end
    if (wr_en_b) begin
        mem[addr_b] <= wr_data_b;
    end
end

// memory output register, then a second output stage
always_ff @(posedge pcie_clk) begin
    if (rd_en_a) begin
        q_a <= mem[addr_a];
    end
    if (rd_en_b) begin
        q_b <= mem[addr_b];
    end
    rd_data_a <= q_a;
    rd_data_b <= q_b;
end

endmodule

/* queue_table/queue_table_bank.sv */
`timescale 1ns/100ps
`include "pcie_qm_config.svh"

module queue_table_bank
    import pcie_qm_pkg::*;
(
    input  logic                            pcie_clk,
    input  logic                            pcie_reset_n,
    qtable_if.bank                          host,
    input  logic                            lookup_en,
    input  logic [`QM_QUEUE_IDX_WIDTH-1:0]  lookup_queue,
    input  logic                            tail_wr_en,
    input  logic [`QM_QUEUE_IDX_WIDTH-1:0]  tail_wr_queue,
    input  logic [`QM_WORD_WIDTH-1:0]       new_tail,
    output queue_ctx_t                      ctx,
    output logic                            ctx_valid
);

localparam int LAT = `QM_RAM_LATENCY;

porta_op_t                      porta_op;
logic                           tail_bypass;
logic                           head_bypass;
logic                           tail_rd_en_a;
logic                           tail_wr_en_a;
logic                           head_rd_en_a;
logic [`QM_QUEUE_IDX_WIDTH-1:0] tail_addr_a;
logic [`QM_WORD_WIDTH-1:0]      tail_q_a;
logic [`QM_WORD_WIDTH-1:0]      head_q_a;
logic [`QM_WORD_WIDTH-1:0]      laddr_q_a;
logic [`QM_WORD_WIDTH-1:0]      haddr_q_a;

logic [LAT-1:0]                      lookup_pipe;
logic [LAT-1:0]                      rd_en_pipe;
logic [LAT-1:0]                      tail_byp_pipe;
logic [LAT-1:0]                      head_byp_pipe;
logic [LAT-1:0][`QM_WORD_WIDTH-1:0]  new_tail_pipe;
logic [LAT-1:0][`QM_WORD_WIDTH-1:0]  head_wr_pipe;

// lookup beats tail update on port A
always_comb begin
    if (lookup_en) begin
        porta_op = PORTA_LOOKUP;
    end else if (tail_wr_en) begin
        porta_op = PORTA_TAIL_WR;
    end else begin
        porta_op = PORTA_IDLE;
    end
end

// same-queue writes in the lookup cycle are forwarded instead of read
assign tail_bypass = lookup_en && tail_wr_en && (lookup_queue == tail_wr_queue);
assign head_bypass = lookup_en && host.head_wr_en && (lookup_queue == host.addr);

// a forwarded tail frees the tail port, so the write still lands
assign tail_rd_en_a = (porta_op == PORTA_LOOKUP) && !tail_bypass;
assign tail_wr_en_a = (porta_op == PORTA_TAIL_WR) || tail_bypass;
assign tail_addr_a  = tail_rd_en_a ? lookup_queue : tail_wr_queue;
assign head_rd_en_a = (porta_op == PORTA_LOOKUP) && !head_bypass;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        lookup_pipe   <= '0;
        rd_en_pipe    <= '0;
        tail_byp_pipe <= '0;
        head_byp_pipe <= '0;
    end else begin
        lookup_pipe   <= {lookup_pipe[LAT-2:0], lookup_en};
        rd_en_pipe    <= {rd_en_pipe[LAT-2:0], host.rd_en};
        tail_byp_pipe <= {tail_byp_pipe[LAT-2:0], tail_bypass};
        head_byp_pipe <= {head_byp_pipe[LAT-2:0], head_bypass};
    end
end

always_ff @(posedge pcie_clk) begin
    new_tail_pipe <= {new_tail_pipe[LAT-2:0], new_tail};
    head_wr_pipe  <= {head_wr_pipe[LAT-2:0], host.head_wr_data};
end

assign ctx_valid     = lookup_pipe[LAT-1];
assign host.rd_valid = rd_en_pipe[LAT-1];

always_comb begin
    ctx.tail     = tail_byp_pipe[LAT-1] ? new_tail_pipe[LAT-1] : tail_q_a;
    ctx.head     = head_byp_pipe[LAT-1] ? head_wr_pipe[LAT-1] : head_q_a;
    ctx.buf_addr = {haddr_q_a, laddr_q_a};
end

////////////////////////////////////////////////////////////////////////////
// context tables, port A fabric side and port B host side
////////////////////////////////////////////////////////////////////////////

qtable_ram tail_ram (
    .pcie_clk  (pcie_clk),
    .addr_a    (tail_addr_a),
    .addr_b    (host.addr),
    .wr_data_a (new_tail),
    .wr_data_b ('0),
    .rd_en_a   (tail_rd_en_a),
    .rd_en_b   (host.rd_en),
    .wr_en_a   (tail_wr_en_a),
    .wr_en_b   (1'b0),
    .rd_data_a (tail_q_a),
    .rd_data_b (host.rd_tail)
);

qtable_ram head_ram (
    .pcie_clk  (pcie_clk),
    .addr_a    (lookup_queue),
    .addr_b    (host.addr),
    .wr_data_a ('0),
    .wr_data_b (host.head_wr_data),
    .rd_en_a   (head_rd_en_a),
    .rd_en_b   (host.rd_en),
    .wr_en_a   (1'b0),
    .wr_en_b   (host.head_wr_en),
    .rd_data_a (head_q_a),
    .rd_data_b (host.rd_head)
);

qtable_ram laddr_ram (
    .pcie_clk  (pcie_clk),
    .addr_a    (lookup_queue),
    .addr_b    (host.addr),
    .wr_data_a ('0),
    .wr_data_b (host.laddr_wr_data),
    .rd_en_a   (porta_op == PORTA_LOOKUP),
    .rd_en_b   (host.rd_en),
    .wr_en_a   (1'b0),
    .wr_en_b   (host.laddr_wr_en),
    .rd_data_a (laddr_q_a),
    .rd_data_b (host.rd_laddr)
);

qtable_ram haddr_ram (
    .pcie_clk  (pcie_clk),
    .addr_a    (lookup_queue),
    .addr_b    (host.addr),
    .wr_data_a ('0),
    .wr_data_b (host.haddr_wr_data),
    .rd_en_a   (porta_op == PORTA_LOOKUP),
    .rd_en_b   (host.rd_en),
    .wr_en_a   (1'b0),
    .wr_en_b   (host.haddr_wr_en),
    .rd_data_a (haddr_q_a),
    .rd_data_b (host.rd_haddr)
);

// valid lines up with the table word stored at the lookup edge
ctx_valid_latency: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    lookup_en |-> ##(LAT) (ctx_valid &&
        ctx.buf_addr[`QM_WORD_WIDTH-1:0] == $past(laddr_ram.mem[lookup_queue], LAT)));

endmodule

/* src/mmio_decoder.sv */
`timescale 1ns/100ps
`include "pcie_qm_config.svh"

module mmio_decoder
    import pcie_qm_pkg::*;
(
    input  logic                            pcie_clk,
    input  logic                            pcie_reset_n,
    input  logic [`QM_PCIE_ADDR_WIDTH-1:0]  pcie_address,
    input  logic                            pcie_write,
    input  logic                            pcie_read,
    input  logic [`QM_PCIE_DATA_WIDTH-1:0]  pcie_writedata,
    input  logic [`QM_PCIE_BE_WIDTH-1:0]    pcie_byteenable,
    qtable_if.ctrl                          dsc_port,
    qtable_if.ctrl                          pkt_port
);

localparam int PKT = `QM_RING_SLOTS;

mmio_op_t                       op;
rd_state_t                      rd_state;
logic [`QM_QUEUE_IDX_WIDTH-1:0] page_idx;
logic [`QM_QUEUE_IDX_WIDTH-1:0] rd_queue;

// a slot is written only with all four byte enables set
function automatic logic slot_full(input int slot);
    return &pcie_byteenable[slot*`QM_REG_BYTES +: `QM_REG_BYTES];
endfunction

function automatic logic [`QM_WORD_WIDTH-1:0] slot_word(input int slot);
    return pcie_writedata[slot*`QM_WORD_WIDTH +: `QM_WORD_WIDTH];
endfunction

assign page_idx = pcie_address[`QM_PAGE_LSB +: `QM_QUEUE_IDX_WIDTH];

// writes go first, a pending read waits for a write-free cycle
always_comb begin
    if (pcie_write) begin
        op = MMIO_WRITE;
    end else if (rd_state == RD_PENDING) begin
        op = MMIO_READ;
    end else begin
        op = MMIO_IDLE;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        rd_state             <= RD_IDLE;
        dsc_port.rd_en       <= 1'b0;
        dsc_port.head_wr_en  <= 1'b0;
        dsc_port.laddr_wr_en <= 1'b0;
        dsc_port.haddr_wr_en <= 1'b0;
        pkt_port.rd_en       <= 1'b0;
        pkt_port.head_wr_en  <= 1'b0;
        pkt_port.laddr_wr_en <= 1'b0;
        pkt_port.haddr_wr_en <= 1'b0;
    end else begin
        // both rings read in the same cycle
        dsc_port.rd_en       <= (op == MMIO_READ);
        pkt_port.rd_en       <= (op == MMIO_READ);

        // tail slots are owned by the fabric side
        dsc_port.head_wr_en  <= (op == MMIO_WRITE) && slot_full(`QM_SLOT_HEAD);
        dsc_port.laddr_wr_en <= (op == MMIO_WRITE) && slot_full(`QM_SLOT_LADDR);
        dsc_port.haddr_wr_en <= (op == MMIO_WRITE) && slot_full(`QM_SLOT_HADDR);
        pkt_port.head_wr_en  <= (op == MMIO_WRITE) && slot_full(PKT + `QM_SLOT_HEAD);
        pkt_port.laddr_wr_en <= (op == MMIO_WRITE) && slot_full(PKT + `QM_SLOT_LADDR);
        pkt_port.haddr_wr_en <= (op == MMIO_WRITE) && slot_full(PKT + `QM_SLOT_HADDR);

        if (op == MMIO_READ) begin
            rd_state <= RD_IDLE;
        end
        // only one read outstanding at a time
        if (pcie_read) begin
            rd_state <= RD_PENDING;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    if (pcie_read) begin
        rd_queue <= page_idx;
    end

    dsc_port.addr          <= (op == MMIO_WRITE) ? page_idx : rd_queue;
    pkt_port.addr          <= (op == MMIO_WRITE) ? page_idx : rd_queue;
    dsc_port.head_wr_data  <= slot_word(`QM_SLOT_HEAD);
    dsc_port.laddr_wr_data <= slot_word(`QM_SLOT_LADDR);
    dsc_port.haddr_wr_data <= slot_word(`QM_SLOT_HADDR);
    pkt_port.head_wr_data  <= slot_word(PKT + `QM_SLOT_HEAD);
    pkt_port.laddr_wr_data <= slot_word(PKT + `QM_SLOT_LADDR);
    pkt_port.haddr_wr_data <= slot_word(PKT + `QM_SLOT_HADDR);
end

// the shared host port never reads and writes in one cycle, in either ring
rd_excludes_wr: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    (dsc_port.rd_en || pkt_port.rd_en) |->
        !(dsc_port.head_wr_en || dsc_port.laddr_wr_en || dsc_port.haddr_wr_en ||
          pkt_port.head_wr_en || pkt_port.laddr_wr_en || pkt_port.haddr_wr_en));

endmodule

/* src/completion_builder.sv */
`timescale 1ns/100ps
`include "pcie_qm_config.svh"

module completion_builder
    import pcie_qm_pkg::*;
(
    input  logic                            pcie_clk,
    input  logic                            pcie_reset_n,
    qtable_if.sink                          dsc_port,
    qtable_if.sink                          pkt_port,
    input  queue_ctx_t                      dsc_ctx,
    input  queue_ctx_t                      pkt_ctx,
    input  logic                            dsc_ctx_valid,
    input  logic                            pkt_ctx_valid,
    output logic [`QM_PCIE_DATA_WIDTH-1:0]  pcie_readdata,
    output logic                            pcie_readdatavalid,
    output logic                            ctx_valid,
    output logic [`QM_WORD_WIDTH-1:0]       dsc_head,
    output logic [`QM_WORD_WIDTH-1:0]       dsc_tail,
    output logic [2*`QM_WORD_WIDTH-1:0]     dsc_buf_addr,
    output logic [`QM_WORD_WIDTH-1:0]       pkt_head,
    output logic [`QM_WORD_WIDTH-1:0]       pkt_tail,
    output logic [2*`QM_WORD_WIDTH-1:0]     pkt_buf_addr
);

localparam int W    = `QM_WORD_WIDTH;
localparam int RING = `QM_RING_SLOTS * W;

logic [`QM_PCIE_DATA_WIDTH-1:0] completion;

// slots 0-7 hold both rings, slots 8-15 read as zero
always_comb begin
    completion = '0;
    completion[`QM_SLOT_TAIL*W +: W]         = dsc_port.rd_tail;
    completion[`QM_SLOT_HEAD*W +: W]         = dsc_port.rd_head;
    completion[`QM_SLOT_LADDR*W +: W]        = dsc_port.rd_laddr;
    completion[`QM_SLOT_HADDR*W +: W]        = dsc_port.rd_haddr;
    completion[RING + `QM_SLOT_TAIL*W +: W]  = pkt_port.rd_tail;
    completion[RING + `QM_SLOT_HEAD*W +: W]  = pkt_port.rd_head;
    completion[RING + `QM_SLOT_LADDR*W +: W] = pkt_port.rd_laddr;
    completion[RING + `QM_SLOT_HADDR*W +: W] = pkt_port.rd_haddr;
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        pcie_readdata      <= '0;
        pcie_readdatavalid <= 1'b0;
        ctx_valid          <= 1'b0;
    end else begin
        pcie_readdatavalid <= dsc_port.rd_valid;
        ctx_valid          <= dsc_ctx_valid;
        // hold the last completion between reads
        if (dsc_port.rd_valid) begin
            pcie_readdata <= completion;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    if (dsc_ctx_valid) begin
        dsc_head     <= dsc_ctx.head;
        dsc_tail     <= dsc_ctx.tail;
        dsc_buf_addr <= dsc_ctx.buf_addr;
        pkt_head     <= pkt_ctx.head;
        pkt_tail     <= pkt_ctx.tail;
        pkt_buf_addr <= pkt_ctx.buf_addr;
    end
end

// both banks share the decoder and lookup inputs, so they stay in lockstep
banks_in_step: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    (dsc_port.rd_valid == pkt_port.rd_valid) && (dsc_ctx_valid == pkt_ctx_valid));

endmodule

/* src/pcie_qm_top.sv */
`timescale 1ns/100ps
`include "pcie_qm_config.svh"

module pcie_qm_top
    import pcie_qm_pkg::*;
(
    input  logic                              pcie_clk,
    input  logic                              pcie_reset_n,

    // host MMIO
    input  logic [`QM_PCIE_ADDR_WIDTH-1:0]    pcie_address,
    input  logic                              pcie_write,
    input  logic                              pcie_read,
    input  logic [`QM_PCIE_DATA_WIDTH-1:0]    pcie_writedata,
    input  logic [`QM_PCIE_BE_WIDTH-1:0]      pcie_byteenable,
    output logic [`QM_PCIE_DATA_WIDTH-1:0]    pcie_readdata,
    output logic                              pcie_readdatavalid,

    // fabric lookup and tail update
    input  logic                              lookup_en,
    input  logic [`QM_QUEUE_IDX_WIDTH-1:0]    lookup_queue,
    input  logic                              tail_wr_en,
    input  logic [`QM_QUEUE_IDX_WIDTH-1:0]    tail_wr_queue,
    input  logic [`QM_WORD_WIDTH-1:0]         new_dsc_tail,
    input  logic [`QM_WORD_WIDTH-1:0]         new_pkt_tail,
    output logic                              ctx_valid,
    output logic [`QM_WORD_WIDTH-1:0]         dsc_head,
    output logic [`QM_WORD_WIDTH-1:0]         dsc_tail,
    output logic [2*`QM_WORD_WIDTH-1:0]       dsc_buf_addr,
    output logic [`QM_WORD_WIDTH-1:0]         pkt_head,
    output logic [`QM_WORD_WIDTH-1:0]         pkt_tail,
    output logic [2*`QM_WORD_WIDTH-1:0]       pkt_buf_addr
);

qtable_if dsc_if ();
qtable_if pkt_if ();

queue_ctx_t dsc_ctx;
queue_ctx_t pkt_ctx;
logic       dsc_ctx_valid;
logic       pkt_ctx_valid;

mmio_decoder decoder (
    .pcie_clk        (pcie_clk),
    .pcie_reset_n    (pcie_reset_n),
    .pcie_address    (pcie_address),
    .pcie_write      (pcie_write),
    .pcie_read       (pcie_read),
    .pcie_writedata  (pcie_writedata),
    .pcie_byteenable (pcie_byteenable),
    .dsc_port        (dsc_if.ctrl),
    .pkt_port        (pkt_if.ctrl)
);

////////////////////////////////////////////////////////////////////////////
// descriptor and packet rings side by side
////////////////////////////////////////////////////////////////////////////

queue_table_bank dsc_bank (
    .pcie_clk      (pcie_clk),
    .pcie_reset_n  (pcie_reset_n),
    .host          (dsc_if.bank),
    .lookup_en     (lookup_en),
    .lookup_queue  (lookup_queue),
    .tail_wr_en    (tail_wr_en),
    .tail_wr_queue (tail_wr_queue),
    .new_tail      (new_dsc_tail),
    .ctx           (dsc_ctx),
    .ctx_valid     (dsc_ctx_valid)
);

queue_table_bank pkt_bank (
    .pcie_clk      (pcie_clk),
    .pcie_reset_n  (pcie_reset_n),
    .host          (pkt_if.bank),
    .lookup_en     (lookup_en),
    .lookup_queue  (lookup_queue),
    .tail_wr_en    (tail_wr_en),
    .tail_wr_queue (tail_wr_queue),
    .new_tail      (new_pkt_tail),
    .ctx           (pkt_ctx),
    .ctx_valid     (pkt_ctx_valid)
);

completion_builder builder (
    .pcie_clk           (pcie_clk),
    .pcie_reset_n       (pcie_reset_n),
    .dsc_port           (dsc_if.sink),
    .pkt_port           (pkt_if.sink),
    .dsc_ctx            (dsc_ctx),
    .pkt_ctx            (pkt_ctx),
    .dsc_ctx_valid      (dsc_ctx_valid),
    .pkt_ctx_valid      (pkt_ctx_valid),
    .pcie_readdata      (pcie_readdata),
    .pcie_readdatavalid (pcie_readdatavalid),
    .ctx_valid          (ctx_valid),
    .dsc_head           (dsc_head),
    .dsc_tail           (dsc_tail),
    .dsc_buf_addr       (dsc_buf_addr),
    .pkt_head           (pkt_head),
    .pkt_tail           (pkt_tail),
    .pkt_buf_addr       (pkt_buf_addr)
);

endmodule

/* verif/tb_pcie_qm.sv */
`timescale 1ns/100ps
`include "pcie_qm_config.svh"

module tb_pcie_qm;

localparam int    TIMEOUT   = 50;
localparam string DATA_FILE = "verif/pcie_qm_testdata.txt";
localparam int    W         = `QM_WORD_WIDTH;

logic                              pcie_clk = 1'b0;
logic                              pcie_reset_n;
logic [`QM_PCIE_ADDR_WIDTH-1:0]    pcie_address;
logic                              pcie_write;
logic                              pcie_read;
logic [`QM_PCIE_DATA_WIDTH-1:0]    pcie_writedata;
logic [`QM_PCIE_BE_WIDTH-1:0]      pcie_byteenable;
logic [`QM_PCIE_DATA_WIDTH-1:0]    pcie_readdata;
logic                              pcie_readdatavalid;
logic                              lookup_en;
logic [`QM_QUEUE_IDX_WIDTH-1:0]    lookup_queue;
logic                              tail_wr_en;
logic [`QM_QUEUE_IDX_WIDTH-1:0]    tail_wr_queue;
logic [W-1:0]                      new_dsc_tail;
logic [W-1:0]                      new_pkt_tail;
logic                              ctx_valid;
logic [W-1:0]                      dsc_head;
logic [W-1:0]                      dsc_tail;
logic [2*W-1:0]                    dsc_buf_addr;
logic [W-1:0]                      pkt_head;
logic [W-1:0]                      pkt_tail;
logic [2*W-1:0]                    pkt_buf_addr;

// expected slots 0-7 of the next completion
logic [W-1:0] exp_page [8];
int           checks;
int           errors;
int           ops_run;
bit           timed_out;

always #4 pcie_clk = ~pcie_clk;

pcie_qm_top UUT (
    .pcie_clk           (pcie_clk),
    .pcie_reset_n       (pcie_reset_n),
    .pcie_address       (pcie_address),
    .pcie_write         (pcie_write),
    .pcie_read          (pcie_read),
    .pcie_writedata     (pcie_writedata),
    .pcie_byteenable    (pcie_byteenable),
    .pcie_readdata      (pcie_readdata),
    .pcie_readdatavalid (pcie_readdatavalid),
    .lookup_en          (lookup_en),
    .lookup_queue       (lookup_queue),
    .tail_wr_en         (tail_wr_en),
    .tail_wr_queue      (tail_wr_queue),
    .new_dsc_tail       (new_dsc_tail),
    .new_pkt_tail       (new_pkt_tail),
    .ctx_valid          (ctx_valid),
    .dsc_head           (dsc_head),
    .dsc_tail           (dsc_tail),
    .dsc_buf_addr       (dsc_buf_addr),
    .pkt_head           (pkt_head),
    .pkt_tail           (pkt_tail),
    .pkt_buf_addr       (pkt_buf_addr)
);

////////////////////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////////////////////

// inputs change 1 ns after the rising edge
task automatic next_cycle();
    @(posedge pcie_clk);
    #1;
endtask

task automatic idle(input int n);
    repeat (n) next_cycle();
endtask

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
endtask

function automatic logic [`QM_PCIE_DATA_WIDTH-1:0] place_word(input int slot,
                                                              input logic [W-1:0] val);
    logic [`QM_PCIE_DATA_WIDTH-1:0] v;
    v = '0;
    v[slot*W +: W] = val;
    return v;
endfunction

function automatic logic [`QM_PCIE_BE_WIDTH-1:0] place_mask(input int slot,
                                                            input logic [3:0] m);
    logic [`QM_PCIE_BE_WIDTH-1:0] v;
    v = '0;
    v[slot*`QM_REG_BYTES +: `QM_REG_BYTES] = m;
    return v;
endfunction

task automatic start_write(input logic [3:0] q, input logic [`QM_PCIE_DATA_WIDTH-1:0] data,
                           input logic [`QM_PCIE_BE_WIDTH-1:0] be);
    pcie_address = '0;
    pcie_address[`QM_PAGE_LSB +: `QM_QUEUE_IDX_WIDTH] = q;
    pcie_writedata  = data;
    pcie_byteenable = be;
    pcie_write      = 1'b1;
endtask

task automatic wait_readdata();
    int n;
    n = 0;
    while (pcie_readdatavalid !== 1'b1 && n < TIMEOUT) begin
        next_cycle();
        n++;
    end
    if (pcie_readdatavalid !== 1'b1) begin
        $display("timeout: no read completion within %0d cycles", TIMEOUT);
        errors++;
        timed_out = 1'b1;
    end
endtask

task automatic wait_ctx();
    int n;
    n = 0;
    while (ctx_valid !== 1'b1 && n < TIMEOUT) begin
        next_cycle();
        n++;
    end
    if (ctx_valid !== 1'b1) begin
        $display("timeout: no lookup result within %0d cycles", TIMEOUT);
        errors++;
        timed_out = 1'b1;
    end
endtask

task automatic check_ctx(input logic [W-1:0] dh, input logic [W-1:0] dt,
                         input logic [2*W-1:0] da, input logic [W-1:0] ph,
                         input logic [W-1:0] pt, input logic [2*W-1:0] pa);
    check_value("dsc_head", dsc_head, dh);
    check_value("dsc_tail", dsc_tail, dt);
    check_value("dsc_buf_addr", dsc_buf_addr, da);
    check_value("pkt_head", pkt_head, ph);
    check_value("pkt_tail", pkt_tail, pt);
    check_value("pkt_buf_addr", pkt_buf_addr, pa);
endtask

// upper eight slots always read back as zero
task automatic check_page();
    for (int s = 0; s < 16; s++) begin
        check_value($sformatf("pcie_readdata word %0d", s), pcie_readdata[s*W +: W],
                    (s < 8) ? exp_page[s] : '0);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// one data line
////////////////////////////////////////////////////////////////////////////

task automatic run_line(input string line);
    logic [7:0]     op;
    logic [3:0]     q;
    logic [3:0]     mask;
    int             slot;
    int             kind;
    int             n;
    bit             bad;
    logic [W-1:0]   v0;
    logic [W-1:0]   v1;
    logic [W-1:0]   e_dh;
    logic [W-1:0]   e_dt;
    logic [W-1:0]   e_ph;
    logic [W-1:0]   e_pt;
    logic [2*W-1:0] e_da;
    logic [2*W-1:0] e_pa;

    bad = 1'b0;
    op  = line.getc(0);
    case (op)
        8'h00, "#", "\n", "\r", " ": begin
        end
        "W": begin
            n = $sscanf(line, "%c %h %h %h %h", op, q, slot, mask, v0);
            if (n == 5) begin
                start_write(q, place_word(slot, v0), place_mask(slot, mask));
                next_cycle();
                pcie_write = 1'b0;
                idle(2);
            end else begin
                bad = 1'b1;
            end
        end
        "T": begin
            n = $sscanf(line, "%c %h %h %h", op, q, v0, v1);
            if (n == 4) begin
                tail_wr_en    = 1'b1;
                tail_wr_queue = q;
                new_dsc_tail  = v0;
                new_pkt_tail  = v1;
                next_cycle();
                tail_wr_en = 1'b0;
                idle(2);
            end else begin
                bad = 1'b1;
            end
        end
        "L", "B": begin
            if (op == "L") begin
                kind = 2;
                n = $sscanf(line, "%c %h %h %h %h %h %h %h", op, q,
                            e_dh, e_dt, e_da, e_ph, e_pt, e_pa) + 3;
            end else begin
                n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", op, q, kind, v0, v1,
                            e_dh, e_dt, e_da, e_ph, e_pt, e_pa);
            end
            if (n == 11) begin
                // head write reaches the table one cycle after the host write
                if (kind == 1) begin
                    start_write(q, place_word(`QM_SLOT_HEAD, v0) |
                                   place_word(`QM_RING_SLOTS + `QM_SLOT_HEAD, v1),
                                place_mask(`QM_SLOT_HEAD, 4'hf) |
                                place_mask(`QM_RING_SLOTS + `QM_SLOT_HEAD, 4'hf));
                    next_cycle();
                    pcie_write = 1'b0;
                end
                lookup_en    = 1'b1;
                lookup_queue = q;
                if (kind == 0) begin
                    tail_wr_en    = 1'b1;
                    tail_wr_queue = q;
                    new_dsc_tail  = v0;
                    new_pkt_tail  = v1;
                end
                next_cycle();
                lookup_en  = 1'b0;
                tail_wr_en = 1'b0;
                wait_ctx();
                if (!timed_out) begin
                    check_ctx(e_dh, e_dt, e_da, e_ph, e_pt, e_pa);
                end
                idle(2);
            end else begin
                bad = 1'b1;
            end
        end
        "R": begin
            n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h", op, q, slot, mask, v0,
                        exp_page[0], exp_page[1], exp_page[2], exp_page[3],
                        exp_page[4], exp_page[5], exp_page[6], exp_page[7]);
            if (n == 13) begin
                pcie_read = 1'b1;
                pcie_address = '0;
                pcie_address[`QM_PAGE_LSB +: `QM_QUEUE_IDX_WIDTH] = q;
                next_cycle();
                pcie_read = 1'b0;
                // a write right behind the pending read
                if (mask != 4'h0) begin
                    start_write(q, place_word(slot, v0), place_mask(slot, mask));
                    next_cycle();
                    pcie_write = 1'b0;
                end
                wait_readdata();
                if (!timed_out) begin
                    check_page();
                end
                idle(2);
            end else begin
                bad = 1'b1;
            end
        end
        default: begin
            $display("unknown opcode in data line: %s", line);
            errors++;
        end
    endcase
    if (bad) begin
        $display("malformed data line: %s", line);
        errors++;
    end else if (op == "W" || op == "T" || op == "L" || op == "B" || op == "R") begin
        ops_run++;
    end
endtask

////////////////////////////////////////////////////////////////////////////
// main sequence
////////////////////////////////////////////////////////////////////////////

initial begin
    int    fd;
    string line;

    checks          = 0;
    errors          = 0;
    ops_run         = 0;
    timed_out       = 1'b0;
    pcie_reset_n    = 1'b0;
    pcie_address    = '0;
    pcie_write      = 1'b0;
    pcie_read       = 1'b0;
    pcie_writedata  = '0;
    pcie_byteenable = '0;
    lookup_en       = 1'b0;
    lookup_queue    = '0;
    tail_wr_en      = 1'b0;
    tail_wr_queue   = '0;
    new_dsc_tail    = '0;
    new_pkt_tail    = '0;

    idle(10);
    pcie_reset_n = 1'b1;
    next_cycle();

    // outputs right after reset
    check_value("pcie_readdatavalid", pcie_readdatavalid, 0);
    check_value("ctx_valid", ctx_valid, 0);
    for (int s = 0; s < 16; s++) begin
        check_value($sformatf("pcie_readdata word %0d", s), pcie_readdata[s*W +: W], 0);
    end

    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
        $display("could not open the stimulus file %s", DATA_FILE);
        errors++;
    end else begin
        while (!$feof(fd) && !timed_out) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
                run_line(line);
            end
        end
        $fclose(fd);
        if (ops_run == 0) begin
            $display("the stimulus file holds no operations");
            errors++;
        end
    end

    $display("operations %0d checks %0d errors %0d", ops_run, checks, errors);
    if (errors == 0) begin
        $display("TESTS PASSED");
    end else begin
        $display("TESTS FAILED");
    end
    $finish;
end

endmodule

/* verif/pcie_qm_testdata.txt */
# T q dsc_tail pkt_tail | W q slot be_mask data | L q dh dt daddr ph pt paddr (64-bit addr)
# B q kind(0 tail, 1 head) dsc_val pkt_val dh dt daddr ph pt paddr
# R q wslot wmask wdata slot0..slot7 (wmask 0 means no write behind the read)
T 3 00000010 00000020
W 3 1 f 11110001
W 3 2 f 22220002
W 3 3 f 33330003
W 3 5 f 55550005
W 3 6 f 66660006
W 3 7 f 77770007
R 3 0 0 0 00000010 11110001 22220002 33330003 00000020 55550005 66660006 77770007
W 3 1 7 deadbeef
W 3 6 e deadbeef
W 3 0 f bad00000
W 3 4 f bad00004
R 3 0 0 0 00000010 11110001 22220002 33330003 00000020 55550005 66660006 77770007
T 3 00000011 00000021
L 3 11110001 00000011 3333000322220002 55550005 00000021 7777000766660006
T 5 00000a00 00000b00
W 5 1 f a1a1a1a1
W 5 2 f a2a2a2a2
W 5 3 f a3a3a3a3
W 5 5 f b1b1b1b1
W 5 6 f b2b2b2b2
W 5 7 f b3b3b3b3
L 5 a1a1a1a1 00000a00 a3a3a3a3a2a2a2a2 b1b1b1b1 00000b00 b3b3b3b3b2b2b2b2
B 5 0 00000a01 00000b01 a1a1a1a1 00000a01 a3a3a3a3a2a2a2a2 b1b1b1b1 00000b01 b3b3b3b3b2b2b2b2
B 5 1 c1c1c1c1 d1d1d1d1 c1c1c1c1 00000a01 a3a3a3a3a2a2a2a2 d1d1d1d1 00000b01 b3b3b3b3b2b2b2b2
L 5 c1c1c1c1 00000a01 a3a3a3a3a2a2a2a2 d1d1d1d1 00000b01 b3b3b3b3b2b2b2b2
R 5 2 f e2e2e2e2 00000a01 c1c1c1c1 e2e2e2e2 a3a3a3a3 00000b01 d1d1d1d1 b2b2b2b2 b3b3b3b3
L 5 c1c1c1c1 00000a01 a3a3a3a3e2e2e2e2 d1d1d1d1 00000b01 b3b3b3b3b2b2b2b2
T 9 00000900 00000901
W 9 1 f 90000001
W 9 2 f 90000002
W 9 3 f 90000003
W 9 5 f 90000005
W 9 6 f 90000006
W 9 7 f 90000007
R 9 0 0 0 00000900 90000001 90000002 90000003 00000901 90000005 90000006 90000007
L 9 90000001 00000900 9000000390000002 90000005 00000901 9000000790000006
R 3 0 0 0 00000011 11110001 22220002 33330003 00000021 55550005 66660006 77770007

/* flist.f */
+incdir+common
common/pcie_qm_pkg.sv
common/qtable_if.sv
queue_table/qtable_ram.sv
queue_table/queue_table_bank.sv
src/mmio_decoder.sv
src/completion_builder.sv
src/pcie_qm_top.sv
verif/tb_pcie_qm.sv

/* Makefile */
TOP = tb_pcie_qm

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
